/* tb.f */
+incdir+.
cu_pkg.sv
cu_if.sv
instr_decoder.sv
ctrl_pipe.sv
redirect_ctrl.sv
control_unit.sv
tb_control_unit.sv

/* Makefile */
# Verilator build, run and lint for the control unit

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f tb.f --top-module tb_control_unit -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "Done: no errors"

lint:
	verilator --lint-only -Wall -I. --top-module control_unit \
		cu_pkg.sv cu_if.sv instr_decoder.sv ctrl_pipe.sv redirect_ctrl.sv control_unit.sv

clean:
	rm -rf obj_dir

/* tb_ref_model.svh */
////////////////////////////////////////////////////////////////////////////
// Reference model for the control unit testbench: expected decode of one
// RV32I word, the two-deep EX queue and the flush registers.
// Included in the testbench module body after the cu_pkg import.
////////////////////////////////////////////////////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    logic                  alu_imm;
    alu_a_sel_e            a_sel;
    alu_op_e               op;
    wb_sel_e               wb;
    logic                  rf_w_en;
    logic                  st_en;
    logic [`CU_MASK_W-1:0] mask;
    logic                  uns;
    logic [4:0]            flow;    // {branch, jump, ecall, ebreak, mret}
    logic                  csr_r;
    logic                  csr_w;
    csr_op_e               csr_op;
    csr_addr_t             csr_addr;
    csr_src_e              csr_src;
} exp_dec_t;

exp_dec_t ex_q[$];    // [0] sits in EX, [1] in ID
logic     nop_id_m;
logic     nop_ex_m;

function automatic alu_op_e expect_arith(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return alt ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic alu_op_e expect_cmp(input logic [2:0] f3);
    case (f3)
        3'd0:    return ALU_EQ;
        3'd1:    return ALU_NE;
        3'd4:    return ALU_LT;
        3'd5:    return ALU_GE;
        3'd6:    return ALU_LTU;
        default: return ALU_GEU;
    endcase
endfunction

function automatic exp_dec_t expect_decode(input logic [31:0] w);
    exp_dec_t   d;
    logic [2:0] f3;
    f3 = w[14:12];
    d = '0;             // Enum zero values are the idle selects
    d.alu_imm = 1'b1;
    case (w[6:0])
        7'b0110011:
        begin
            d.alu_imm = 1'b0;
            d.op      = expect_arith(f3, w[30]);
            d.rf_w_en = 1'b1;
        end
        7'b0010011:
        begin
            d.op      = expect_arith(f3, w[30] && f3 == 3'd5);
            d.rf_w_en = 1'b1;
        end
        7'b0000011:
        begin
            d.wb      = WB_MEM;
            d.rf_w_en = 1'b1;
            d.mask    = (f3[1:0] == 2'd0) ? 4'h1 : (f3[1:0] == 2'd1) ? 4'h3 : 4'hf;
            d.uns     = f3[2];
        end
        7'b0100011:
        begin
            d.st_en = 1'b1;
            d.mask  = (f3 == 3'd0) ? 4'h1 : (f3 == 3'd1) ? 4'h3 : 4'hf;
        end
        7'b1100011:
        begin
            d.a_sel = A_PC;
            d.op    = expect_cmp(f3);
            d.flow  = 5'b10000;
        end
        7'b1101111, 7'b1100111:
        begin
            d.a_sel   = w[3] ? A_PC : A_RS1;    // JAL is PC relative, JALR is not
            d.wb      = WB_PC4;
            d.rf_w_en = 1'b1;
            d.flow    = 5'b01000;
        end
        7'b0110111, 7'b0010111:
        begin
            d.a_sel   = w[5] ? A_ZERO : A_PC;    // LUI or AUIPC
            d.rf_w_en = 1'b1;
        end
        7'b1110011:
        begin
            if (f3 == 3'd0)
            begin
                d.csr_r    = 1'b1;
                d.csr_addr = (w[31:20] == 12'h302) ? `CU_CSR_MEPC : `CU_CSR_MTVEC;
                d.flow     = (w[31:20] == 12'h000) ? 5'b00100 :
                             (w[31:20] == 12'h001) ? 5'b00010 : 5'b00001;
            end
            else
            begin
                d.wb       = WB_CSR;
                d.csr_op   = csr_op_e'(f3);
                d.csr_addr = w[31:20];
                d.csr_src  = f3[2] ? CSR_SRC_ZIMM : CSR_SRC_REG;
                d.csr_w    = (f3[1:0] == 2'd1) ? 1'b1 : (w[19:15] != 5'd0);
                d.csr_r    = (f3[1:0] == 2'd1) ? (w[11:7] != 5'd0) : 1'b1;
                d.rf_w_en  = d.csr_r;
            end
        end
        default: ;
    endcase
    return d;
endfunction

// Misaligned access outside a flush turns the EX command into a mtvec read
function automatic exp_dec_t csr_view(input exp_dec_t ex, input logic mis, input logic nop);
    exp_dec_t c;
    c = ex;
    if (mis && !nop)
    begin
        c.csr_r    = 1'b1;
        c.csr_w    = 1'b0;
        c.csr_op   = CSR_NONE;
        c.csr_addr = `CU_CSR_MTVEC;
        c.csr_src  = CSR_SRC_TRAP;
    end
    return c;
endfunction

function automatic logic redirect_cond(input exp_dec_t ex, input logic taken,
                                       input logic mis);
    return (ex.flow[4] && taken) || (ex.flow[3:0] != 4'd0) || mis;
endfunction

task automatic model_reset();
    ex_q.delete();
    ex_q.push_back('0);
    ex_q.push_back('0);
    nop_id_m = 1'b0;
    nop_ex_m = 1'b0;
endtask

// One clock edge of the flush chain and the IF -> ID -> EX shift
task automatic model_step(input exp_dec_t dec, input logic flush);
    nop_ex_m = flush || nop_id_m;
    nop_id_m = flush;
    ex_q.push_back(dec);
    void'(ex_q.pop_front());
endtask

`endif

/* tb_control_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the control unit. Random RV32I words from a fixed seed,
// checked every cycle against the decode and flush model.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cu_config.svh"

module tb_control_unit;
    import cu_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 2000;
    localparam int E_DEC      = 0;
    localparam int E_CSR      = 1;
    localparam int E_FLUSH    = 2;
    localparam int E_RST      = 3;

    logic                  clk;
    logic                  rst_n;
    logic                  fetch;
    logic [`CU_XLEN-1:0]   instr;
    logic                  is_misaligned;
    logic                  branch_true;
    logic                  alu_imm;
    alu_a_sel_e            alu_a_sel;
    alu_op_e               alu_op;
    wb_sel_e               wb_sel;
    logic                  rf_w_en;
    logic                  st_en;
    logic [`CU_MASK_W-1:0] ldst_mask;
    logic                  ldst_unsigned;
    logic                  branch;
    logic                  jump;
    logic                  ecall;
    logic                  ebreak;
    logic                  mret;
    logic                  csr_r_en;
    logic                  csr_w_en;
    csr_op_e               csr_op;
    csr_addr_t             csr_addr;
    csr_src_e              csr_src;
    logic                  make_nop;

    integer seed;
    int     errs [4];

    `include "tb_ref_model.svh"

    exp_dec_t if_dec;
    logic     redirect;

    control_unit dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Register field with a bias towards x0
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[7:6] == 2'b00) ? 5'd0 : r[4:0];
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] sel;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        r   = $random(seed);
        sel = $random(seed);
        rd  = pick_reg();
        rs1 = pick_reg();
        f3  = sel[6:4];
        case (sel[3:0])
            4'd0, 4'd1:
                return {1'b0, r[30], 5'b0, r[24:20], rs1, f3, rd, 7'b0110011};
            4'd2, 4'd3:
                return {r[31:20], rs1, f3, rd, 7'b0010011};
            4'd4, 4'd5:
                return {r[31:20], rs1, sel[7] ? 3'd2 : {sel[6], 1'b0, sel[5]}, rd, 7'b0000011};
            4'd6:
                return {r[31:20], rs1, (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]}, r[11:7],
                        7'b0100011};
            4'd7, 4'd8:
                return {r[31:20], rs1, {f3[2] | f3[1], f3[1:0]}, r[11:7], 7'b1100011};
            4'd9:
                return {r[31:12], rd, 7'b1101111};
            4'd10:
                return {r[31:20], rs1, 3'd0, rd, 7'b1100111};
            4'd11:
                return {r[31:12], rd, 7'b0110111};
            4'd12:
                return {r[31:12], rd, 7'b0010111};
            4'd13:    // ECALL, EBREAK or MRET
                return {(f3[1:0] == 2'd0) ? 12'h000 : (f3[1:0] == 2'd1) ? 12'h001 : 12'h302,
                        5'd0, 3'd0, 5'd0, 7'b1110011};
            default:
                return {r[31:20], rs1, {f3[2:1], f3[0] | ~f3[1]}, rd, 7'b1110011};
        endcase
    endfunction

    task automatic report_mismatch(input string name, input int cat,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("error %s: expected %h, actual %h, instr %h", name, exp, act, instr);
        errs[cat]++;
    endtask

    task automatic check_reset();
        if (make_nop !== 1'b0)
            report_mismatch("reset make_nop", E_RST, 32'd0, 32'(make_nop));
        if (csr_r_en !== 1'b0)
            report_mismatch("reset csr_r_en", E_RST, 32'd0, 32'(csr_r_en));
        if (csr_w_en !== 1'b0)
            report_mismatch("reset csr_w_en", E_RST, 32'd0, 32'(csr_w_en));
        if (fetch !== 1'b0)
            report_mismatch("reset fetch", E_RST, 32'd0, 32'(fetch));
    endtask

    task automatic check_cycle(input exp_dec_t d);
        exp_dec_t c;
        c = csr_view(ex_q[0], is_misaligned, nop_ex_m);
        if ({alu_imm, alu_a_sel, alu_op} !== {d.alu_imm, d.a_sel, d.op})
            report_mismatch("decode alu", E_DEC, 32'({d.alu_imm, d.a_sel, d.op}),
                            32'({alu_imm, alu_a_sel, alu_op}));
        if ({wb_sel, rf_w_en} !== {d.wb, d.rf_w_en})
            report_mismatch("decode writeback", E_DEC, 32'({d.wb, d.rf_w_en}),
                            32'({wb_sel, rf_w_en}));
        if ({st_en, ldst_mask, ldst_unsigned} !== {d.st_en, d.mask, d.uns})
            report_mismatch("decode load/store", E_DEC, 32'({d.st_en, d.mask, d.uns}),
                            32'({st_en, ldst_mask, ldst_unsigned}));
        if ({branch, jump, ecall, ebreak, mret} !== d.flow)
            report_mismatch("decode flow flags", E_DEC, 32'(d.flow),
                            32'({branch, jump, ecall, ebreak, mret}));
        if (make_nop !== nop_ex_m)
            report_mismatch("flush make_nop", E_FLUSH, 32'(nop_ex_m), 32'(make_nop));
        if ({csr_r_en, csr_w_en} !== {c.csr_r, c.csr_w})
            report_mismatch("csr enables", E_CSR, 32'({c.csr_r, c.csr_w}),
                            32'({csr_r_en, csr_w_en}));
        if (csr_op !== c.csr_op)
            report_mismatch("csr op", E_CSR, 32'(c.csr_op), 32'(csr_op));
        if ({csr_addr, csr_src} !== {c.csr_addr, c.csr_src})
            report_mismatch("csr addr and src", E_CSR, 32'({c.csr_addr, c.csr_src}),
                            32'({csr_addr, csr_src}));
        if (fetch !== 1'b1)
            report_mismatch("fetch after reset", E_RST, 32'd1, 32'(fetch));
    endtask

    initial
    begin
        logic [31:0] draw;
        int          total;
        seed          = 96776;
        clk           = 1'b0;
        rst_n         = 1'b0;
        instr         = 32'h0000_0013;    // addi x0, x0, 0
        is_misaligned = 1'b0;
        branch_true   = 1'b0;
        errs          = '{0, 0, 0, 0};
        model_reset();
        repeat (8)
        begin
            @(negedge clk);
            check_reset();
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            draw          = $random(seed);
            instr         = random_instr();
            is_misaligned = (draw[3:0] == 4'd0);
            branch_true   = draw[4];
            if_dec        = expect_decode(instr);
            @(negedge clk);
            check_cycle(if_dec);
            redirect = redirect_cond(ex_q[0], branch_true, is_misaligned) && !nop_ex_m;
            @(posedge clk);
            model_step(if_dec, redirect);
            #1;
        end
        total = errs[0] + errs[1] + errs[2] + errs[3];
        $display("Error counts: decode %0d, csr %0d, flush %0d, reset %0d",
                 errs[E_DEC], errs[E_CSR], errs[E_FLUSH], errs[E_RST]);
        if (total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        #((NUM_TESTS + 20) * CLK_PERIOD);
        $display("Watchdog timeout: the test sequence did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

/* control_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Control unit top of the three-stage RV32I core. Decodes in IF, carries
// flags and the CSR command to EX and drives the flush. Plain ports only.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cu_config.svh"

module control_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic                  fetch,
    input  logic [`CU_XLEN-1:0]   instr,
    input  logic                  is_misaligned,
    input  logic                  branch_true,
    output logic                  alu_imm,
    output cu_pkg::alu_a_sel_e    alu_a_sel,
    output cu_pkg::alu_op_e       alu_op,
    output cu_pkg::wb_sel_e       wb_sel,
    output logic                  rf_w_en,
    output logic                  st_en,
    output logic [`CU_MASK_W-1:0] ldst_mask,
    output logic                  ldst_unsigned,
    output logic                  branch,
    output logic                  jump,
    output logic                  ecall,
    output logic                  ebreak,
    output logic                  mret,
    output logic                  csr_r_en,
    output logic                  csr_w_en,
    output cu_pkg::csr_op_e       csr_op,
    output cu_pkg::csr_addr_t     csr_addr,
    output cu_pkg::csr_src_e      csr_src,
    output logic                  make_nop
);
    import cu_pkg::*;

    logic      csr_r_en_ex;
    logic      csr_w_en_ex;
    csr_op_e   csr_op_ex;
    csr_addr_t csr_addr_ex;
    csr_src_e  csr_src_ex;

    csr_cmd_if csr_if_i ();
    flow_if    flow_ex_i ();

    assign fetch = rst_n;

    instr_decoder decoder_i (
        .instr         (instr),
        .alu_imm       (alu_imm),
        .alu_a_sel     (alu_a_sel),
        .alu_op        (alu_op),
        .wb_sel        (wb_sel),
        .rf_w_en       (rf_w_en),
        .st_en         (st_en),
        .ldst_mask     (ldst_mask),
        .ldst_unsigned (ldst_unsigned),
        .branch        (branch),
        .jump          (jump),
        .ecall         (ecall),
        .ebreak        (ebreak),
        .mret          (mret),
        .csr           (csr_if_i.dec)
    );

    ctrl_pipe pipe_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .branch      (branch),
        .jump        (jump),
        .ecall       (ecall),
        .ebreak      (ebreak),
        .mret        (mret),
        .csr_in      (csr_if_i.pipe),
        .flow_ex     (flow_ex_i.src),
        .csr_r_en_ex (csr_r_en_ex),
        .csr_w_en_ex (csr_w_en_ex),
        .csr_op_ex   (csr_op_ex),
        .csr_addr_ex (csr_addr_ex),
        .csr_src_ex  (csr_src_ex)
    );

    redirect_ctrl redirect_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_true   (branch_true),
        .is_misaligned (is_misaligned),
        .csr_r_en_ex   (csr_r_en_ex),
        .csr_w_en_ex   (csr_w_en_ex),
        .csr_op_ex     (csr_op_ex),
        .csr_addr_ex   (csr_addr_ex),
        .csr_src_ex    (csr_src_ex),
        .flow_ex       (flow_ex_i.dst),
        .make_nop      (make_nop),
        .csr_r_en      (csr_r_en),
        .csr_w_en      (csr_w_en),
        .csr_op        (csr_op),
        .csr_addr      (csr_addr),
        .csr_src       (csr_src)
    );

endmodule

/* redirect_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Pipeline flush on taken branches, jumps, traps and misaligned accesses.
// Drives make_nop for two cycles and swaps in the mtvec trap read.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cu_config.svh"

module redirect_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               branch_true,
    input  logic               is_misaligned,
    input  logic               csr_r_en_ex,
    input  logic               csr_w_en_ex,
    input  cu_pkg::csr_op_e    csr_op_ex,
    input  cu_pkg::csr_addr_t  csr_addr_ex,
    input  cu_pkg::csr_src_e   csr_src_ex,
    flow_if.dst                flow_ex,
    output logic               make_nop,
    output logic               csr_r_en,
    output logic               csr_w_en,
    output cu_pkg::csr_op_e    csr_op,
    output cu_pkg::csr_addr_t  csr_addr,
    output cu_pkg::csr_src_e   csr_src
);
    import cu_pkg::*;

    logic nop_if;    // Kill of the instruction now in IF
    logic nop_id;
    logic nop_ex;
    logic trap;

    // Ignored while the flush is still draining
    assign nop_if = ((flow_ex.branch && branch_true) || flow_ex.jump || flow_ex.ecall
                     || flow_ex.ebreak || flow_ex.mret || is_misaligned) && !nop_ex;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            nop_id <= 1'b0;
            nop_ex <= 1'b0;
        end
        else
        begin
            nop_id <= nop_if;
            nop_ex <= nop_if || nop_id;    // Bubble from ID keeps it high a 2nd cycle
        end
    end

    assign make_nop = nop_ex;

    // Misaligned access: read mtvec for the trap target
    assign trap     = is_misaligned && !nop_ex;
    assign csr_r_en = trap ? 1'b1 : csr_r_en_ex;
    assign csr_w_en = trap ? 1'b0 : csr_w_en_ex;
    assign csr_op   = trap ? CSR_NONE : csr_op_ex;
    assign csr_addr = trap ? `CU_CSR_MTVEC : csr_addr_ex;
    assign csr_src  = trap ? CSR_SRC_TRAP : csr_src_ex;

    a_flush_two_cycles: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(make_nop) |=> make_nop ##1 !make_nop);

endmodule

/* ctrl_pipe.sv */
////////////////////////////////////////////////////////////////////////////
// IF -> ID -> EX registers for the control-flow flags and the CSR command.
// Values reach EX two clock edges after the instruction is decoded.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_pipe (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               branch,
    input  logic               jump,
    input  logic               ecall,
    input  logic               ebreak,
    input  logic               mret,
    csr_cmd_if.pipe            csr_in,
    flow_if.src                flow_ex,
    output logic               csr_r_en_ex,
    output logic               csr_w_en_ex,
    output cu_pkg::csr_op_e    csr_op_ex,
    output cu_pkg::csr_addr_t  csr_addr_ex,
    output cu_pkg::csr_src_e   csr_src_ex
);
    import cu_pkg::*;

    typedef struct packed {
        logic    branch;
        logic    jump;
        logic    ecall;
        logic    ebreak;
        logic    mret;
        logic    r_en;
        logic    w_en;
        csr_op_e op;
    } ctrl_t;

    ctrl_t     ctrl_if;
    ctrl_t     ctrl_id;
    ctrl_t     ctrl_ex;
    csr_addr_t addr_id;
    csr_addr_t addr_ex;
    csr_src_e  src_id;
    csr_src_e  src_ex;

    assign ctrl_if = '{branch, jump, ecall, ebreak, mret, csr_in.r_en, csr_in.w_en, csr_in.op};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ctrl_id <= '0;
            ctrl_ex <= '0;
            addr_id <= '0;
            addr_ex <= '0;
            src_id  <= CSR_SRC_REG;
            src_ex  <= CSR_SRC_REG;
        end
        else
        begin
            ctrl_id <= ctrl_if;
            ctrl_ex <= ctrl_id;
            addr_id <= csr_in.addr;
            addr_ex <= addr_id;
            src_id  <= csr_in.src;
            src_ex  <= src_id;
        end
    end

    assign flow_ex.branch = ctrl_ex.branch;
    assign flow_ex.jump   = ctrl_ex.jump;
    assign flow_ex.ecall  = ctrl_ex.ecall;
    assign flow_ex.ebreak = ctrl_ex.ebreak;
    assign flow_ex.mret   = ctrl_ex.mret;

    assign csr_r_en_ex = ctrl_ex.r_en;
    assign csr_w_en_ex = ctrl_ex.w_en;
    assign csr_op_ex   = ctrl_ex.op;
    assign csr_addr_ex = addr_ex;
    assign csr_src_ex  = src_ex;

    // A CSR write reaching EX must carry a real operation
    a_wen_has_op: assert property (@(posedge clk) disable iff (!rst_n)
        csr_w_en_ex |-> (csr_op_ex != CSR_NONE));

endmodule

/* instr_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// Combinational RV32I decode. Turns one instruction word into datapath
// selects, IF-stage flags and the CSR command for the pipe.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cu_config.svh"

module instr_decoder (
    input  logic [`CU_XLEN-1:0]   instr,
    output logic                  alu_imm,
    output cu_pkg::alu_a_sel_e    alu_a_sel,
    output cu_pkg::alu_op_e       alu_op,
    output cu_pkg::wb_sel_e       wb_sel,
    output logic                  rf_w_en,
    output logic                  st_en,
    output logic [`CU_MASK_W-1:0] ldst_mask,
    output logic                  ldst_unsigned,
    output logic                  branch,
    output logic                  jump,
    output logic                  ecall,
    output logic                  ebreak,
    output logic                  mret,
    csr_cmd_if.dec                csr
);
    import cu_pkg::*;

    rv_opcode_e opcode;
    logic [2:0] funct3;
    logic       rd_zero;
    logic       rs1_zero;

    assign opcode   = rv_opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rd_zero  = (instr[11:7] == 5'd0);
    assign rs1_zero = (instr[19:15] == 5'd0);

    // Register and immediate ALU ops share funct3; SUB only exists for R-type
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
        case (f3)
            3'b000:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic logic [`CU_MASK_W-1:0] size_mask(input logic [1:0] size);
        case (size)
            2'b00:   return 4'b0001;
            2'b01:   return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    always_comb
    begin
        alu_imm       = 1'b1;
        alu_a_sel     = A_RS1;
        alu_op        = ALU_ADD;
        wb_sel        = WB_ALU;
        rf_w_en       = 1'b0;
        st_en         = 1'b0;
        ldst_mask     = '0;
        ldst_unsigned = 1'b0;
        branch        = 1'b0;
        jump          = 1'b0;
        ecall         = 1'b0;
        ebreak        = 1'b0;
        mret          = 1'b0;
        csr.r_en      = 1'b0;
        csr.w_en      = 1'b0;
        csr.op        = CSR_NONE;
        csr.addr      = '0;
        csr.src       = CSR_SRC_REG;

        case (opcode)
            OPC_R:
            begin
                alu_imm = 1'b0;
                alu_op  = arith_op(funct3, instr[30], 1'b1);
                rf_w_en = 1'b1;
            end
            OPC_I:
            begin
                alu_op  = arith_op(funct3, instr[30], 1'b0);
                rf_w_en = 1'b1;
            end
            OPC_LOAD:
            begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                begin
                    rf_w_en       = 1'b1;
                    wb_sel        = WB_MEM;
                    ldst_mask     = size_mask(funct3[1:0]);
                    ldst_unsigned = funct3[2];    // LBU, LHU
                end
            end
            OPC_STORE:
            begin
                if (funct3 inside {3'b000, 3'b001, 3'b010})
                begin
                    st_en     = 1'b1;
                    ldst_mask = size_mask(funct3[1:0]);
                end
            end
            OPC_BRANCH:
            begin
                if (funct3[2:1] != 2'b01)
                begin
                    alu_a_sel = A_PC;
                    branch    = 1'b1;
                    case (funct3)
                        3'b000:  alu_op = ALU_EQ;
                        3'b001:  alu_op = ALU_NE;
                        3'b100:  alu_op = ALU_LT;
                        3'b101:  alu_op = ALU_GE;
                        3'b110:  alu_op = ALU_LTU;
                        default: alu_op = ALU_GEU;
                    endcase
                end
            end
            OPC_JAL:
            begin
                alu_a_sel = A_PC;
                jump      = 1'b1;
                rf_w_en   = 1'b1;
                wb_sel    = WB_PC4;
            end
            OPC_JALR:
            begin
                jump    = 1'b1;
                rf_w_en = 1'b1;
                wb_sel  = WB_PC4;
            end
            OPC_LUI:
            begin
                alu_a_sel = A_ZERO;
                rf_w_en   = 1'b1;
            end
            OPC_AUIPC:
            begin
                alu_a_sel = A_PC;
                rf_w_en   = 1'b1;
            end
            OPC_SYSTEM:
            begin
                if (funct3 == 3'b000)
                begin
                    // Trap entry and return fetch their target from a CSR
                    case (instr[31:20])
                        12'h000:
                        begin
                            ecall    = 1'b1;
                            csr.r_en = 1'b1;
                            csr.addr = `CU_CSR_MTVEC;
                        end
                        12'h001:
                        begin
                            ebreak   = 1'b1;
                            csr.r_en = 1'b1;
                            csr.addr = `CU_CSR_MTVEC;
                        end
                        12'h302:
                        begin
                            mret     = 1'b1;
                            csr.r_en = 1'b1;
                            csr.addr = `CU_CSR_MEPC;
                        end
                        default: ;
                    endcase
                end
                else if (funct3 != 3'b100)
                begin
                    wb_sel   = WB_CSR;
                    csr.op   = csr_op_e'(funct3);
                    csr.addr = instr[31:20];
                    csr.src  = funct3[2] ? CSR_SRC_ZIMM : CSR_SRC_REG;
                    if (funct3[1:0] == 2'b01)    // CSRRW(I): no read side effect for rd 0
                    begin
                        rf_w_en  = !rd_zero;
                        csr.r_en = !rd_zero;
                        csr.w_en = 1'b1;
                    end
                    else                         // Set/clear with rs1 0 only reads
                    begin
                        rf_w_en  = 1'b1;
                        csr.r_en = 1'b1;
                        csr.w_en = !rs1_zero;
                    end
                end
            end
            default: ;    // FENCE and unknown opcodes decode as no-op
        endcase

        assert ($onehot0({branch, jump, ecall, ebreak, mret}))
        else $error("decoder raised more than one control-flow flag");
    end

endmodule

/* cu_if.sv */
////////////////////////////////////////////////////////////////////////////
// Internal bundles of the control unit. csr_cmd_if moves the decoded CSR
// command into the pipe, flow_if carries the EX control-flow flags.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface csr_cmd_if;
    import cu_pkg::*;

    logic      r_en;
    logic      w_en;
    csr_op_e   op;
    csr_addr_t addr;
    csr_src_e  src;

    modport dec (output r_en, w_en, op, addr, src);
    modport pipe (input r_en, w_en, op, addr, src);
endinterface

interface flow_if;
    logic branch;
    logic jump;
    logic ecall;
    logic ebreak;
    logic mret;

    modport src (output branch, jump, ecall, ebreak, mret);
    modport dst (input branch, jump, ecall, ebreak, mret);
endinterface

/* cu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Types shared by the control unit: RV32I major opcodes, ALU operations,
// datapath selects and the CSR command encodings.
////////////////////////////////////////////////////////////////////////////

`include "cu_config.svh"

package cu_pkg;

    typedef logic [`CU_CSR_ADDR_W-1:0] csr_addr_t;

    typedef enum logic [6:0] {
        OPC_R      = 7'b0110011,
        OPC_I      = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_EQ,      // Branch compares
        ALU_NE,
        ALU_LT,
        ALU_GE,
        ALU_LTU,
        ALU_GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        A_RS1,
        A_PC,
        A_ZERO
    } alu_a_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_CSR
    } wb_sel_e;

    // Same values as funct3 of the CSR instructions
    typedef enum logic [2:0] {
        CSR_NONE = 3'd0,
        CSR_RW   = 3'd1,
        CSR_RS   = 3'd2,
        CSR_RC   = 3'd3,
        CSR_RWI  = 3'd5,
        CSR_RSI  = 3'd6,
        CSR_RCI  = 3'd7
    } csr_op_e;

    typedef enum logic [1:0] {
        CSR_SRC_REG,
        CSR_SRC_ZIMM,
        CSR_SRC_TRAP
    } csr_src_e;

endpackage

/* cu_config.svh */
////////////////////////////////////////////////////////////////////////////
// Widths and CSR addresses for the instruction-decode control unit.
// Include in any file that needs an instruction, mask or CSR constant.
////////////////////////////////////////////////////////////////////////////

`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// Instruction word
`define CU_XLEN 32

// CSR address space
`define CU_CSR_ADDR_W 12
`define CU_CSR_MTVEC 12'h305
`define CU_CSR_MEPC 12'h341

// Load/store byte enables
`define CU_MASK_W 4

`endif
